// File: design/mpu_consts.svh
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Sizes of the program map manager

// Map table
`define MAP_ENTRIES       8          // Table slots
`define MAP_INDEX_W       3          // Slot index bits

// Instruction memory
`define THREAD_MEM_SIZE   1024       // Words shared by all threads

// Address, length and used size bits, wide enough for the value 1024
`define ADDRESS_W         11

// Thread identifiers
`define THREAD_ID_W       4

`endif

// File: design/mpuPkg.sv
`default_nettype none

`include "mpu_consts.svh"

package mpuPkg;

	typedef logic [`THREAD_ID_W-1:0] threadId_t;
	typedef logic [`ADDRESS_W-1:0]   mpuAddress_t;

	// One row of the map table
	typedef struct packed {
		logic        valid;
		threadId_t   threadId;
		mpuAddress_t address;        // Base of the program in instruction memory
		mpuAddress_t length;         // Program size in words
	} mapEntry_t;

	// Store side, READY means a store may be acknowledged
	typedef enum logic {
		STORE_IDLE  = 1'b0,
		STORE_READY = 1'b1
	} storeState_e;

	// Lookup side, RESPOND is the answer cycle
	typedef enum logic {
		LOOKUP_IDLE    = 1'b0,
		LOOKUP_RESPOND = 1'b1
	} lookupState_e;

endpackage

`default_nettype wire

// File: design/ringBufferCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "mpu_consts.svh"

// Slot allocator for the map table. Slots are handed out in ring order,
// while pops may free any slot, so only the occupancy is tracked here

module ringBufferCtrl (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    push,         // Slot taken at writeIndex
	input  logic                    pop,          // Some slot freed
	output logic [`MAP_INDEX_W-1:0] writeIndex,
	output logic [`MAP_INDEX_W:0]   entryCount,
	output logic                    full
);

	logic [`MAP_INDEX_W-1:0] writePointer;
	logic [`MAP_INDEX_W:0]   count;
	logic                    pointerAtEnd;

	////////////////////////////////////////////////////////////////////////////
	// Write pointer
	////////////////////////////////////////////////////////////////////////////

	assign pointerAtEnd = (writePointer == `MAP_INDEX_W'(`MAP_ENTRIES - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			writePointer <= '0;
		end else if (push) begin
			if (pointerAtEnd) begin
				writePointer <= '0;              // Wrap around
			end else begin
				writePointer <= writePointer + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Idle, or push and pop cancel
			endcase
		end
	end

	assign full       = (count == (`MAP_INDEX_W+1)'(`MAP_ENTRIES));
	assign writeIndex = writePointer;
	assign entryCount = count;

endmodule

`default_nettype wire

// File: design/mapManager.sv
`timescale 1ns/100ps
`default_nettype none

`include "mpu_consts.svh"

// Program map manager. Records base address and length per thread,
// answers lookups one cycle after the request and frees the hit entry

module mapManager (
	input  logic                    clock,
	input  logic                    reset,
	// Store side
	input  logic                    storeReq,
	input  mpuPkg::threadId_t       storeThreadId,
	input  mpuPkg::mpuAddress_t     storeLength,
	output logic                    storeAck,
	// Lookup side
	input  logic                    lookupReq,
	input  mpuPkg::threadId_t       lookupThreadId,
	output logic                    lookupAck,
	output logic                    lookupHit,
	output mpuPkg::mpuAddress_t     threadAddress,
	output mpuPkg::mpuAddress_t     threadLength,
	output mpuPkg::mpuAddress_t     usedSize,
	// Slot allocator
	input  logic [`MAP_INDEX_W-1:0] writeIndex,
	input  logic                    tableFull,
	output logic                    push,
	output logic                    pop
);

	import mpuPkg::*;

	mapEntry_t               mapTable [`MAP_ENTRIES];

	storeState_e             storeState;
	lookupState_e            lookupState;

	logic [`MAP_ENTRIES-1:0] matchVector;
	logic [`MAP_INDEX_W-1:0] searchIndex;      // Lowest matching slot
	logic                    searchFound;
	logic [`MAP_INDEX_W-1:0] matchIndex;       // Held for the answer cycle
	logic                    matchFound;

	logic [`ADDRESS_W:0]     spaceNeeded;      // One extra bit against overflow
	logic                    spaceOk;
	logic                    slotFree;

	mpuAddress_t             usedSizeReg;
	mpuAddress_t             addAmount;
	mpuAddress_t             subAmount;
	mpuAddress_t             hitAddress;
	mpuAddress_t             hitLength;

	////////////////////////////////////////////////////////////////////////////
	// Lookup search
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `MAP_ENTRIES; i++) begin
			matchVector[i] = mapTable[i].valid & (mapTable[i].threadId == lookupThreadId);
		end
	end

	// Priority encoder, lowest index wins
	always_comb begin
		searchIndex = '0;
		searchFound = 1'b0;
		for (int i = `MAP_ENTRIES - 1; i >= 0; i--) begin
			if (matchVector[i]) begin
				searchIndex = `MAP_INDEX_W'(i);
				searchFound = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookupReq) begin
			matchIndex <= searchIndex;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			matchFound <= 1'b0;
		end else if (lookupReq) begin
			matchFound <= searchFound;
		end
	end

	// Answer cycle outputs
	assign lookupAck     = (lookupState == LOOKUP_RESPOND);
	assign lookupHit     = lookupAck & matchFound;
	assign hitAddress    = mapTable[matchIndex].address;
	assign hitLength     = mapTable[matchIndex].length;
	assign threadAddress = lookupHit ? hitAddress : '0;     // Zero on a miss
	assign threadLength  = lookupHit ? hitLength : '0;
	assign pop           = lookupHit;

	////////////////////////////////////////////////////////////////////////////
	// Store acceptance
	////////////////////////////////////////////////////////////////////////////

	assign spaceNeeded = {1'b0, usedSizeReg} + {1'b0, storeLength};
	assign spaceOk     = (spaceNeeded <= (`ADDRESS_W+1)'(`THREAD_MEM_SIZE));
	assign slotFree    = ~mapTable[writeIndex].valid;

	assign storeAck = (storeState == STORE_READY) & storeReq & slotFree & ~tableFull & spaceOk;
	assign push     = storeAck;

	////////////////////////////////////////////////////////////////////////////
	// Map table
	////////////////////////////////////////////////////////////////////////////

	// A store never lands on the slot being freed, that slot is still valid
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MAP_ENTRIES; i++) begin
				mapTable[i].valid <= 1'b0;
			end
		end else begin
			if (storeAck) begin
				mapTable[writeIndex].valid    <= 1'b1;
				mapTable[writeIndex].threadId <= storeThreadId;
				mapTable[writeIndex].address  <= usedSizeReg;    // Base is the current fill
				mapTable[writeIndex].length   <= storeLength;
			end
			if (lookupHit) begin
				mapTable[matchIndex].valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Used size
	////////////////////////////////////////////////////////////////////////////

	assign addAmount = storeAck ? storeLength : '0;
	assign subAmount = lookupHit ? hitLength : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			usedSizeReg <= '0;
		end else begin
			usedSizeReg <= usedSizeReg + addAmount - subAmount;   // Net change
		end
	end

	assign usedSize = usedSizeReg;

	////////////////////////////////////////////////////////////////////////////
	// Control FSMs
	////////////////////////////////////////////////////////////////////////////

	// Store side rests one cycle after each accepted store
	always_ff @(posedge clock) begin
		if (reset) begin
			storeState <= STORE_READY;
		end else begin
			case (storeState)
				STORE_READY: begin
					if (storeAck) begin
						storeState <= STORE_IDLE;
					end
				end
				STORE_IDLE: begin
					storeState <= STORE_READY;
				end
				default: storeState <= STORE_READY;
			endcase
		end
	end

	// Lookup side answers exactly one cycle after the request
	always_ff @(posedge clock) begin
		if (reset) begin
			lookupState <= LOOKUP_IDLE;
		end else begin
			case (lookupState)
				LOOKUP_IDLE: begin
					if (lookupReq) begin
						lookupState <= LOOKUP_RESPOND;
					end
				end
				LOOKUP_RESPOND: begin
					if (lookupReq) begin
						lookupState <= LOOKUP_RESPOND;
					end else begin
						lookupState <= LOOKUP_IDLE;
					end
				end
				default: lookupState <= LOOKUP_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/mpuMapUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mpu_consts.svh"

// Top of the program map unit, manager plus slot allocator

module mpuMapUnit (
	input  logic                  clock,
	input  logic                  reset,
	// Store requests from instruction memory
	input  logic                  storeReq,
	input  mpuPkg::threadId_t     storeThreadId,
	input  mpuPkg::mpuAddress_t   storeLength,
	output logic                  storeAck,
	// Lookup requests from dispatch
	input  logic                  lookupReq,
	input  mpuPkg::threadId_t     lookupThreadId,
	output logic                  lookupAck,
	output logic                  lookupHit,
	output mpuPkg::mpuAddress_t   threadAddress,
	output mpuPkg::mpuAddress_t   threadLength,
	// Status
	output mpuPkg::mpuAddress_t   usedSize,
	output logic                  tableFull,
	output logic [`MAP_INDEX_W:0] entryCount
);

	logic [`MAP_INDEX_W-1:0] writeIndex;
	logic                    push;
	logic                    pop;

	////////////////////////////////////////////////////////////////////////////
	// Map manager
	////////////////////////////////////////////////////////////////////////////

	mapManager manager (
		.clock          (clock),
		.reset          (reset),
		.storeReq       (storeReq),
		.storeThreadId  (storeThreadId),
		.storeLength    (storeLength),
		.storeAck       (storeAck),
		.lookupReq      (lookupReq),
		.lookupThreadId (lookupThreadId),
		.lookupAck      (lookupAck),
		.lookupHit      (lookupHit),
		.threadAddress  (threadAddress),
		.threadLength   (threadLength),
		.usedSize       (usedSize),
		.writeIndex     (writeIndex),
		.tableFull      (tableFull),
		.push           (push),
		.pop            (pop)
	);

	// Slot allocation in ring order
	ringBufferCtrl slotRing (
		.clock      (clock),
		.reset      (reset),
		.push       (push),
		.pop        (pop),
		.writeIndex (writeIndex),
		.entryCount (entryCount),
		.full       (tableFull)
	);

endmodule

`default_nettype wire

// File: test/mpuMapUnit_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "mpu_consts.svh"

module mpuMapUnit_sva (
	input logic                clock,
	input logic                reset,
	input logic                storeReq,
	input logic                storeAck,
	input logic                lookupReq,
	input logic                lookupAck,
	input logic                tableFull,
	input mpuPkg::mpuAddress_t usedSize
);

	// Store acknowledge rules
	assert property (@(posedge clock) disable iff (reset) storeAck |-> storeReq)
		else $error("storeAck raised without storeReq");
	assert property (@(posedge clock) disable iff (reset) tableFull |-> !storeAck)
		else $error("storeAck raised while the table is full");

	// Lookup answer exactly one cycle after the request
	assert property (@(posedge clock) disable iff (reset) lookupReq |=> lookupAck)
		else $error("lookupAck missing one cycle after lookupReq");
	assert property (@(posedge clock) disable iff (reset) lookupAck |-> $past(lookupReq))
		else $error("lookupAck without a lookupReq in the cycle before");
	assert property (@(posedge clock) disable iff (reset) lookupAck |-> !lookupReq)
		else $error("lookupReq raised in the answer cycle");

	assert property (@(posedge clock) disable iff (reset) usedSize <= `THREAD_MEM_SIZE)
		else $error("usedSize beyond the instruction memory size");

endmodule

bind mapManager mpuMapUnit_sva protocolChecks (
	.clock     (clock),
	.reset     (reset),
	.storeReq  (storeReq),
	.storeAck  (storeAck),
	.lookupReq (lookupReq),
	.lookupAck (lookupAck),
	.tableFull (tableFull),
	.usedSize  (usedSize)
);

`default_nettype wire

// File: test/mpuMapUnit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mpu_consts.svh"

module mpuMapUnit_tb;

	import mpuPkg::*;

	localparam int CLOCK_PERIOD   = 8;
	localparam int RESET_CYCLES   = 16;
	localparam int FILL_CYCLES    = 48;
	localparam int LOOKUP_COUNT   = 4;
	localparam int SPACE_CYCLES   = 40;
	localparam int MIXED_CYCLES   = 300;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + FILL_CYCLES + 4 * LOOKUP_COUNT
		+ SPACE_CYCLES + MIXED_CYCLES + 8;
	localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2 + 100;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  storeReq;
	threadId_t             storeThreadId;
	mpuAddress_t           storeLength;
	logic                  storeAck;
	logic                  lookupReq;
	threadId_t             lookupThreadId;
	logic                  lookupAck;
	logic                  lookupHit;
	mpuAddress_t           threadAddress;
	mpuAddress_t           threadLength;
	mpuAddress_t           usedSize;
	logic                  tableFull;
	logic [`MAP_INDEX_W:0] entryCount;

	// Reference model of the table and the accounting
	mapEntry_t             modelSlots [`MAP_ENTRIES];
	int                    modelWritePtr;
	int                    modelCount;
	mpuAddress_t           modelUsed;
	logic                  modelReady;         // Store side may acknowledge
	logic                  answerDue;          // Lookup answer in this cycle
	logic                  answerFound;
	int                    answerIndex;

	int                    errorCount = 0;
	int                    checkTotal = 0;
	int                    testNumber = 0;
	int                    failedTests = 0;
	int                    testErrorBase;
	int                    cycleCount = 0;
	logic                  accepted;
	logic                  pendingStore;
	threadId_t             pendingId;
	mpuAddress_t           pendingLength;
	int                    storesDone;

	mpuMapUnit UUT (.*);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare and report
	////////////////////////////////////////////////////////////////////////////

	task automatic checkAddress(input string name, input mpuAddress_t actual,
		input mpuAddress_t expected);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkCount(input string name, input logic [`MAP_INDEX_W:0] actual,
		input logic [`MAP_INDEX_W:0] expected);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic reportFailure(input string text);
		errorCount++;
		$display("%s", text);
	endtask

	task automatic openTest();
		testNumber++;
		testErrorBase = errorCount;
	endtask

	task automatic closeTest(input string name);
		if (errorCount == testErrorBase) begin
			$display("test %0d %s: ok", testNumber, name);
		end else begin
			failedTests++;
			$display("test %0d %s: %0d errors", testNumber, name, errorCount - testErrorBase);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Model helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int lowestMatch(input threadId_t id);
		int found;
		found = -1;
		for (int i = 0; i < `MAP_ENTRIES; i++) begin
			if (found < 0 && modelSlots[i].valid && modelSlots[i].threadId == id) begin
				found = i;
			end
		end
		return found;
	endfunction

	// ID of a random valid slot or zero on an empty table
	function automatic threadId_t pickStoredId();
		int start;
		int slot;
		threadId_t id;
		start = $urandom_range(`MAP_ENTRIES - 1);
		id = '0;
		for (int k = `MAP_ENTRIES - 1; k >= 0; k--) begin
			slot = (start + k) % `MAP_ENTRIES;
			if (modelSlots[slot].valid) begin
				id = modelSlots[slot].threadId;
			end
		end
		return id;
	endfunction

	// One clock cycle starting just after a falling edge
	task automatic applyCycle(input logic sReq, input threadId_t sId, input mpuAddress_t sLen,
		input logic lReq, input threadId_t lId, output logic ack);
		logic        expectAck;
		logic        expectHit;
		mpuAddress_t expectAddress;
		mpuAddress_t expectLength;
		mpuAddress_t usedBefore;
		int          searchResult;

		storeReq       = sReq;
		storeThreadId  = sId;
		storeLength    = sLen;
		lookupReq      = lReq;
		lookupThreadId = lId;
		#(CLOCK_PERIOD / 4);

		expectAck = modelReady && sReq && !modelSlots[modelWritePtr].valid
			&& modelCount < `MAP_ENTRIES
			&& (int'(modelUsed) + int'(sLen) <= `THREAD_MEM_SIZE);
		expectHit     = answerDue && answerFound;
		expectAddress = expectHit ? modelSlots[answerIndex].address : '0;
		expectLength  = expectHit ? modelSlots[answerIndex].length : '0;

		checkFlag("storeAck", storeAck, expectAck);
		checkFlag("lookupAck", lookupAck, answerDue);
		checkFlag("lookupHit", lookupHit, expectHit);
		checkAddress("threadAddress", threadAddress, expectAddress);
		checkAddress("threadLength", threadLength, expectLength);
		checkAddress("usedSize", usedSize, modelUsed);
		checkFlag("tableFull", tableFull, modelCount == `MAP_ENTRIES);
		checkCount("entryCount", entryCount, (`MAP_INDEX_W+1)'(modelCount));

		// Lookup sees the table before this edge
		searchResult = lowestMatch(lId);
		usedBefore   = modelUsed;
		if (expectAck) begin
			modelSlots[modelWritePtr].valid    = 1'b1;
			modelSlots[modelWritePtr].threadId = sId;
			modelSlots[modelWritePtr].address  = usedBefore;
			modelSlots[modelWritePtr].length   = sLen;
			modelWritePtr = (modelWritePtr + 1) % `MAP_ENTRIES;
			modelCount++;
		end
		if (expectHit) begin
			modelSlots[answerIndex].valid = 1'b0;
			modelCount--;
		end
		modelUsed   = usedBefore + (expectAck ? sLen : '0) - expectLength;
		modelReady  = !expectAck;                  // One rest cycle after a store
		answerDue   = lReq;
		answerFound = (searchResult >= 0);
		answerIndex = answerFound ? searchResult : 0;
		ack = storeAck;
		@(negedge clock);
	endtask

	task automatic lookupOnce(input threadId_t id);
		applyCycle(1'b0, '0, '0, 1'b1, id, accepted);
		applyCycle(1'b0, '0, '0, 1'b0, '0, accepted);    // Answer cycle
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h3c92_4d6e));
		reset          = 1'b1;
		storeReq       = 1'b0;
		storeThreadId  = '0;
		storeLength    = '0;
		lookupReq      = 1'b0;
		lookupThreadId = '0;
		for (int i = 0; i < `MAP_ENTRIES; i++) begin
			modelSlots[i] = '0;
		end
		modelWritePtr = 0;
		modelCount    = 0;
		modelUsed     = '0;
		modelReady    = 1'b1;
		answerDue     = 1'b0;
		answerFound   = 1'b0;
		answerIndex   = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		openTest();
		applyCycle(1'b0, '0, '0, 1'b0, '0, accepted);
		closeTest("state after reset");

		// IDs 0 to 3 only so duplicates are certain
		openTest();
		pendingStore = 1'b0;
		for (int c = 0; c < FILL_CYCLES; c++) begin
			if (!pendingStore) begin
				pendingId     = threadId_t'($urandom_range(3));
				pendingLength = mpuAddress_t'($urandom_range(100, 1));
				pendingStore  = 1'b1;
			end
			applyCycle(1'b1, pendingId, pendingLength, 1'b0, '0, accepted);
			if (accepted) begin
				pendingStore = 1'b0;
			end
		end
		if (tableFull !== 1'b1) begin
			reportFailure("the table never filled up during the store test");
		end
		applyCycle(1'b0, '0, '0, 1'b0, '0, accepted);
		closeTest("random stores until full");

		openTest();
		for (int n = 0; n < LOOKUP_COUNT; n++) begin
			lookupOnce(pickStoredId());
		end
		closeTest("lookups of stored IDs");

		openTest();
		for (int n = 0; n < LOOKUP_COUNT; n++) begin
			lookupOnce(threadId_t'($urandom_range(15, 8)));
		end
		closeTest("lookups of absent IDs");

		// Length one word beyond the free space
		openTest();
		pendingLength = mpuAddress_t'(`THREAD_MEM_SIZE + 1) - modelUsed;
		storesDone = 0;
		for (int c = 0; c < 4; c++) begin
			applyCycle(1'b1, 4'h5, pendingLength, 1'b0, '0, accepted);
			if (accepted) begin
				storesDone++;
			end
		end
		if (storesDone != 0) begin
			reportFailure("a store was accepted without enough free space");
		end
		for (int c = 0; c < SPACE_CYCLES - 4 && storesDone == 0; c++) begin
			if (answerDue || modelCount == 0) begin
				applyCycle(1'b1, 4'h5, pendingLength, 1'b0, '0, accepted);
			end else begin
				applyCycle(1'b1, 4'h5, pendingLength, 1'b1,
					modelSlots[modelWritePtr].valid ? modelSlots[modelWritePtr].threadId
						: pickStoredId(), accepted);
			end
			if (accepted) begin
				storesDone++;
			end
		end
		if (storesDone == 0) begin
			reportFailure("the long store was never accepted after lookups freed space");
		end
		applyCycle(1'b0, '0, '0, 1'b0, '0, accepted);
		closeTest("store waits for space");

		openTest();
		pendingStore = 1'b0;
		storesDone   = 0;
		for (int c = 0; c < MIXED_CYCLES; c++) begin
			if (!pendingStore && $urandom_range(1) == 1) begin
				pendingId     = threadId_t'($urandom_range(7));
				pendingLength = mpuAddress_t'($urandom_range(160, 1));
				pendingStore  = 1'b1;
			end
			applyCycle(pendingStore, pendingId, pendingLength,
				!answerDue && $urandom_range(2) != 0, threadId_t'($urandom_range(7)), accepted);
			if (accepted) begin
				pendingStore = 1'b0;
				storesDone++;
			end
		end
		if (storesDone < `MAP_ENTRIES) begin
			reportFailure("mixed traffic never wrapped the slot ring");
		end
		applyCycle(1'b0, '0, '0, 1'b0, '0, accepted);
		closeTest("random mixed traffic");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testNumber, failedTests, checkTotal, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mpuMapUnit.f
+incdir+design
design/mpuPkg.sv
design/ringBufferCtrl.sv
design/mapManager.sv
design/mpuMapUnit.sv
test/mpuMapUnit_sva.sv
test/mpuMapUnit_tb.sv
